// File: list.f
source/exu_pkg.sv
source/exu_dispatch.sv
source/exu_alu.sv
source/exu_fakecommit.sv
source/exu_commit_fifo.sv
source/exu_wbu.sv
source/exu_top.sv
verification/exu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the exu testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module exu_tb -o exu_sim
./obj_dir/exu_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// File: source/exu_alu.sv
// exu_alu: single-stage add/sub/xor/link unit with a held output register
`timescale 1ns/1ps

module exu_alu (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 int_assert_i,
    input  logic                 issue_valid_i,
    input  exu_pkg::exu_issue_t  issue_i,
    output logic                 issue_ready_o,
    input  logic                 wb_ready_i,
    output logic                 res_valid_o,
    output exu_pkg::exu_result_t res_o
);
    import exu_pkg::*;

    logic                      res_valid_q;
    exu_result_t               res_q;
    logic [REG_DATA_WIDTH-1:0] alu_out;

    // slot free, or held result leaving this cycle
    assign issue_ready_o = !res_valid_q || wb_ready_i;

    always_comb begin
        unique case (issue_i.inst.op)
            ADD:     alu_out = issue_i.inst.a + issue_i.inst.b;
            SUB:     alu_out = issue_i.inst.a - issue_i.inst.b;
            XOR:     alu_out = issue_i.inst.a ^ issue_i.inst.b;
            JUMP:    alu_out = issue_i.inst.a + 32'd4;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (int_assert_i) begin
            res_valid_q <= 1'b0;
        end else if (issue_ready_o) begin
            res_valid_q <= issue_valid_i;
        end
    end

    // payload only moves on an accepted issue
    always_ff @(posedge clk) begin
        if (issue_valid_i && issue_ready_o) begin
            res_q.rd        <= issue_i.inst.rd;
            res_q.wdata     <= alu_out;
            // writes to x0 are not real writes
            res_q.we        <= (issue_i.inst.rd != ZERO_REG);
            res_q.commit_id <= issue_i.commit_id;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

// File: source/exu_commit_fifo.sv
// exu_commit_fifo: circular buffer of outstanding commit ids in issue order
`timescale 1ns/1ps

module exu_commit_fifo #(
    parameter int COMMIT_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                flush_i,
    input  logic                                push_i,
    input  logic [exu_pkg::COMMIT_ID_WIDTH-1:0] push_id_i,
    input  logic                                pop_i,
    output logic [exu_pkg::COMMIT_ID_WIDTH-1:0] head_id_o,
    output logic                                head_valid_o,
    output logic [$clog2(COMMIT_DEPTH+1)-1:0]   free_o
);
    import exu_pkg::*;

    localparam int PTR_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1;
    localparam int CNT_W = $clog2(COMMIT_DEPTH+1);

    logic [COMMIT_ID_WIDTH-1:0] mem_q [COMMIT_DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [CNT_W-1:0]           count_q;
    logic                       do_push;
    logic                       do_pop;

    // dispatch never pushes when full, wbu never pops when empty
    assign do_push = push_i && (count_q != CNT_W'(COMMIT_DEPTH));
    assign do_pop  = pop_i && (count_q != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // explicit wrap, depth need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(COMMIT_DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(COMMIT_DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush_i) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

    assign head_id_o    = mem_q[rd_ptr_q];
    assign head_valid_o = (count_q != '0);
    assign free_o       = CNT_W'(COMMIT_DEPTH) - count_q;

endmodule

// File: source/exu_dispatch.sv
// exu_dispatch: pair splitter, commit id allocation, routing of the second instruction
`timescale 1ns/1ps

module exu_dispatch #(
    parameter int COMMIT_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                pair_valid_i,
    input  exu_pkg::exu_pair_t                  pair_i,
    output logic                                pair_ready_o,
    input  logic                                int_assert_i,
    output logic                                alu_valid_o,
    output exu_pkg::exu_issue_t                 alu_issue_o,
    input  logic                                alu_ready_i,
    output logic                                fake_req_o,
    output logic [exu_pkg::COMMIT_ID_WIDTH-1:0] fake_id_o,
    input  logic                                fake_ready_i,
    input  logic [$clog2(COMMIT_DEPTH+1)-1:0]   fifo_free_i,
    output logic                                push_o,
    output logic [exu_pkg::COMMIT_ID_WIDTH-1:0] push_id_o
);
    import exu_pkg::*;

    typedef enum logic {
        IDLE,
        SECOND
    } disp_state_e;

    disp_state_e                state_q;
    logic [COMMIT_ID_WIDTH-1:0] cnt_q;
    exu_inst_t                  second_q;
    logic                       jump_q;
    logic                       room_ok;
    logic                       pair_fire;
    logic                       second_fire;

    // both ids of a pair must fit before the pair is taken
    assign room_ok = (fifo_free_i >= 2) && !int_assert_i;

    // first instruction goes straight to the alu
    assign pair_ready_o = (state_q == IDLE) && alu_ready_i && room_ok;
    assign pair_fire    = pair_valid_i && pair_ready_o;

    // pending second, squashed ones go to pseudo-commit
    assign second_fire = (state_q == SECOND) && !int_assert_i &&
                         (jump_q ? fake_ready_i : alu_ready_i);

    assign alu_valid_o = (state_q == IDLE) ? (pair_valid_i && room_ok)
                                           : (!jump_q && !int_assert_i);
    assign alu_issue_o.inst      = (state_q == IDLE) ? pair_i.first : second_q;
    assign alu_issue_o.commit_id = cnt_q;

    assign fake_req_o = (state_q == SECOND) && jump_q && !int_assert_i;
    assign fake_id_o  = cnt_q;

    // id enters the fifo in its issue cycle
    assign push_o    = pair_fire || second_fire;
    assign push_id_o = cnt_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            jump_q  <= 1'b0;
        end else if (int_assert_i) begin
            // drop a half-issued pair, ids restart
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (pair_fire) begin
            state_q <= SECOND;
            cnt_q   <= cnt_q + 1'b1;
            jump_q  <= (pair_i.first.op == JUMP);
        end else if (second_fire) begin
            state_q <= IDLE;
            cnt_q   <= cnt_q + 1'b1;
        end
    end

    // second instruction parked until its unit frees up
    always_ff @(posedge clk) begin
        if (pair_fire) begin
            second_q <= pair_i.second;
        end
    end

endmodule

// File: source/exu_fakecommit.sv
// exu_fakecommit: retires the id of a squashed second instruction as a null x0 write
`timescale 1ns/1ps

module exu_fakecommit (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                req_fakecommit_i,
    input  logic [exu_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i,
    input  logic                                int_assert_i,
    input  logic                                wb_ready_i,
    output logic                                req_ready_o,
    output logic                                res_valid_o,
    output exu_pkg::exu_result_t                res_o
);
    import exu_pkg::*;

    logic                       slot_valid_q;
    logic [COMMIT_ID_WIDTH-1:0] slot_id_q;
    logic                       update;

    // slot reloads when empty or being drained
    assign update      = wb_ready_i || !slot_valid_q;
    assign req_ready_o = update;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid_q <= 1'b0;
        end else if (int_assert_i) begin
            slot_valid_q <= 1'b0;
        end else if (update) begin
            slot_valid_q <= req_fakecommit_i;
        end
    end

    // only the id is carried
    always_ff @(posedge clk) begin
        if (update && req_fakecommit_i) begin
            slot_id_q <= commit_id_i;
        end
    end

    // x0, zero data, no write
    assign res_valid_o     = slot_valid_q;
    assign res_o.rd        = ZERO_REG;
    assign res_o.wdata     = '0;
    assign res_o.we        = 1'b0;
    assign res_o.commit_id = slot_id_q;

endmodule

// File: source/exu_pkg.sv
// exu_pkg: datapath widths, opcode enum, instruction, pair, issue, result and retire structs
package exu_pkg;

    // register file geometry
    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // commit ids wrap modulo 16
    localparam int COMMIT_ID_WIDTH = 4;

    // writes here are dropped by the register file
    localparam logic [REG_ADDR_WIDTH-1:0] ZERO_REG = '0;

    // JUMP only produces the link value a + 4
    typedef enum logic [1:0] {
        ADD  = 2'd0,
        SUB  = 2'd1,
        XOR  = 2'd2,
        JUMP = 2'd3
    } exu_op_e;

    // one decoded instruction, operands already read
    typedef struct packed {
        exu_op_e                   op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_DATA_WIDTH-1:0] a;
        logic [REG_DATA_WIDTH-1:0] b;
    } exu_inst_t;

    // dual-issue bundle, first is older
    typedef struct packed {
        exu_inst_t first;
        exu_inst_t second;
    } exu_pair_t;

    // instruction tagged with its commit id
    typedef struct packed {
        exu_inst_t                  inst;
        logic [COMMIT_ID_WIDTH-1:0] commit_id;
    } exu_issue_t;

    // common result format of both execute units
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [REG_DATA_WIDTH-1:0]  wdata;
        logic                       we;
        logic [COMMIT_ID_WIDTH-1:0] commit_id;
    } exu_result_t;

    // retire record seen at the top level
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [REG_DATA_WIDTH-1:0]  wdata;
        logic                       we;
        logic [COMMIT_ID_WIDTH-1:0] commit_id;
    } exu_retire_t;

endpackage

// File: source/exu_top.sv
// exu_top: dispatch, alu, pseudo-commit, commit fifo and writeback wired together
`timescale 1ns/1ps

module exu_top #(
    parameter int COMMIT_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 pair_valid_i,
    input  exu_pkg::exu_pair_t   pair_i,
    output logic                 pair_ready_o,
    input  logic                 int_assert_i,
    output logic                 retire_valid_o,
    output exu_pkg::exu_retire_t retire_o
);
    import exu_pkg::*;

    // dispatch to execute
    logic                            alu_valid;
    exu_issue_t                      alu_issue;
    logic                            alu_ready;
    logic                            fake_req;
    logic [COMMIT_ID_WIDTH-1:0]      fake_id;
    logic                            fake_ready;
    // commit id tracking
    logic                            push;
    logic [COMMIT_ID_WIDTH-1:0]      push_id;
    logic                            pop;
    logic [COMMIT_ID_WIDTH-1:0]      head_id;
    logic                            head_valid;
    logic [$clog2(COMMIT_DEPTH+1)-1:0] fifo_free;
    // execute to writeback
    logic                            alu_res_valid;
    exu_result_t                     alu_res;
    logic                            wb_alu_ready;
    logic                            fake_res_valid;
    exu_result_t                     fake_res;
    logic                            wb_fake_ready;

    exu_dispatch #(.COMMIT_DEPTH(COMMIT_DEPTH)) i_dispatch (
        .clk(clk), .arst_n_i(arst_n_i), .pair_valid_i(pair_valid_i), .pair_i(pair_i),
        .pair_ready_o(pair_ready_o), .int_assert_i(int_assert_i),
        .alu_valid_o(alu_valid), .alu_issue_o(alu_issue), .alu_ready_i(alu_ready),
        .fake_req_o(fake_req), .fake_id_o(fake_id), .fake_ready_i(fake_ready),
        .fifo_free_i(fifo_free), .push_o(push), .push_id_o(push_id)
    );

    exu_alu i_alu (
        .clk(clk), .arst_n_i(arst_n_i), .int_assert_i(int_assert_i),
        .issue_valid_i(alu_valid), .issue_i(alu_issue), .issue_ready_o(alu_ready),
        .wb_ready_i(wb_alu_ready), .res_valid_o(alu_res_valid), .res_o(alu_res)
    );

    exu_fakecommit i_fakecommit (
        .clk(clk), .arst_n_i(arst_n_i), .req_fakecommit_i(fake_req),
        .commit_id_i(fake_id), .int_assert_i(int_assert_i), .wb_ready_i(wb_fake_ready),
        .req_ready_o(fake_ready), .res_valid_o(fake_res_valid), .res_o(fake_res)
    );

    exu_commit_fifo #(.COMMIT_DEPTH(COMMIT_DEPTH)) i_commit_fifo (
        .clk(clk), .arst_n_i(arst_n_i), .flush_i(int_assert_i), .push_i(push),
        .push_id_i(push_id), .pop_i(pop), .head_id_o(head_id),
        .head_valid_o(head_valid), .free_o(fifo_free)
    );

    exu_wbu i_wbu (
        .clk(clk), .arst_n_i(arst_n_i), .int_assert_i(int_assert_i),
        .alu_valid_i(alu_res_valid), .alu_res_i(alu_res), .alu_ready_o(wb_alu_ready),
        .fake_valid_i(fake_res_valid), .fake_res_i(fake_res), .fake_ready_o(wb_fake_ready),
        .head_id_i(head_id), .head_valid_i(head_valid), .pop_o(pop),
        .retire_valid_o(retire_valid_o), .retire_o(retire_o)
    );

endmodule

// File: source/exu_wbu.sv
// exu_wbu: in-order writeback, matches results against the fifo head and registers the retire
`timescale 1ns/1ps

module exu_wbu (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                int_assert_i,
    input  logic                                alu_valid_i,
    input  exu_pkg::exu_result_t                alu_res_i,
    output logic                                alu_ready_o,
    input  logic                                fake_valid_i,
    input  exu_pkg::exu_result_t                fake_res_i,
    output logic                                fake_ready_o,
    input  logic [exu_pkg::COMMIT_ID_WIDTH-1:0] head_id_i,
    input  logic                                head_valid_i,
    output logic                                pop_o,
    output logic                                retire_valid_o,
    output exu_pkg::exu_retire_t                retire_o
);
    import exu_pkg::*;

    logic        alu_hit;
    logic        fake_hit;
    exu_result_t sel_res;
    logic        retire_valid_q;
    exu_retire_t retire_q;

    // ids are unique in flight, at most one source hits
    assign alu_hit  = alu_valid_i && head_valid_i && !int_assert_i &&
                      (alu_res_i.commit_id == head_id_i);
    assign fake_hit = fake_valid_i && head_valid_i && !int_assert_i &&
                      (fake_res_i.commit_id == head_id_i);

    // a non-head result just waits in its unit
    assign alu_ready_o  = alu_hit;
    assign fake_ready_o = fake_hit;
    assign pop_o        = alu_hit || fake_hit;

    assign sel_res = alu_hit ? alu_res_i : fake_res_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_q <= 1'b0;
        end else begin
            retire_valid_q <= pop_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            retire_q.rd        <= sel_res.rd;
            retire_q.wdata     <= sel_res.wdata;
            retire_q.we        <= sel_res.we;
            retire_q.commit_id <= sel_res.commit_id;
        end
    end

    // retire lags the pop by one cycle
    // an interrupt hides anything still in the register
    assign retire_valid_o = retire_valid_q && !int_assert_i;
    assign retire_o       = retire_q;

endmodule

// File: verification/exu_tb.sv
// exu_tb: clock, reset, lcg stimulus, retire queue model, compare tasks, watchdog, summary
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int COMMIT_DEPTH = 8;
    localparam int N_ARITH      = 24;
    localparam int N_JUMP       = 12;
    localparam int N_WRAP       = 20;
    localparam int N_B2B        = 24;
    localparam int N_INT        = 24;
    localparam int TOTAL_PAIRS  = N_ARITH + N_JUMP + N_WRAP + N_B2B + N_INT;

    logic        clk;
    logic        arst_n_i;
    logic        pair_valid_i;
    exu_pair_t   pair_i;
    logic        pair_ready_o;
    logic        int_assert_i;
    logic        retire_valid_o;
    exu_retire_t retire_o;

    // expected retire stream, oldest first
    exu_retire_t                exp_q[$];
    logic [COMMIT_ID_WIDTH-1:0] model_id;
    logic [31:0]                lcg_state;
    logic                       fired;
    logic                       prev_fire;
    int                         errors;
    int                         checks;
    int                         accepted;
    int                         retired;
    int                         tests;
    int                         errors_at_open;

    exu_top #(.COMMIT_DEPTH(COMMIT_DEPTH)) i_exu_top (
        .clk(clk), .arst_n_i(arst_n_i), .pair_valid_i(pair_valid_i), .pair_i(pair_i),
        .pair_ready_o(pair_ready_o), .int_assert_i(int_assert_i),
        .retire_valid_o(retire_valid_o), .retire_o(retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // numerical recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic exu_inst_t rand_inst(input bit allow_jump);
        exu_inst_t   inst;
        logic [31:0] r;
        r = lcg_next();
        if (allow_jump) begin
            inst.op = exu_op_e'(r[1:0]);
        end else begin
            inst.op = exu_op_e'(2'(r[9:2] % 8'd3));
        end
        // x0 now and then
        inst.rd = (r[13:10] == 4'd0) ? ZERO_REG : r[18:14];
        inst.a  = lcg_next();
        inst.b  = lcg_next();
        return inst;
    endfunction

    // mode 0 arithmetic only, 1 any op, 2 first is a jump
    function automatic exu_pair_t rand_pair(input int mode);
        exu_pair_t p;
        p.first  = rand_inst(mode != 0);
        p.second = rand_inst(mode != 0);
        if (mode == 2) begin
            p.first.op = JUMP;
        end
        return p;
    endfunction

    // reference result of one executed instruction
    function automatic exu_retire_t model_result(input exu_inst_t inst,
                                                 input logic [COMMIT_ID_WIDTH-1:0] id);
        exu_retire_t rec;
        rec.rd        = inst.rd;
        rec.we        = (inst.rd != ZERO_REG);
        rec.commit_id = id;
        case (inst.op)
            ADD:     rec.wdata = inst.a + inst.b;
            SUB:     rec.wdata = inst.a - inst.b;
            XOR:     rec.wdata = inst.a ^ inst.b;
            // jump, link value only
            default: rec.wdata = inst.a + 32'd4;
        endcase
        return rec;
    endfunction

    // squashed second, null write to x0
    function automatic exu_retire_t squash_record(input logic [COMMIT_ID_WIDTH-1:0] id);
        exu_retire_t rec;
        rec.rd        = ZERO_REG;
        rec.wdata     = '0;
        rec.we        = 1'b0;
        rec.commit_id = id;
        return rec;
    endfunction

    task automatic check_retire(input exu_retire_t got, input exu_retire_t exp);
        checks++;
        if (got !== exp) begin
            $display(
                "** Error at %0t: got id %0d rd %0d we %0b %h, exp id %0d rd %0d we %0b %h",
                $time, got.commit_id, got.rd, got.we, got.wdata,
                exp.commit_id, exp.rd, exp.we, exp.wdata);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input integer got, input integer exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
            errors++;
        end
    endtask

    // values seen here hold until the next rising edge
    task automatic observe();
        exu_retire_t exp;
        // second of the last pair still pending
        if (prev_fire) begin
            check_flag("pair_ready_o after a handshake", pair_ready_o, 1'b0);
        end
        prev_fire = 1'b0;
        if (retire_valid_o) begin
            retired++;
            if (exp_q.size() == 0) begin
                $display("retire of id %0d at %0t while no id was outstanding",
                         retire_o.commit_id, $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                check_retire(retire_o, exp);
            end
        end
        if (int_assert_i) begin
            // everything in flight is dropped, ids restart
            exp_q.delete();
            model_id = '0;
            accepted = retired;
        end else if (pair_valid_i && pair_ready_o) begin
            exp_q.push_back(model_result(pair_i.first, model_id));
            if (pair_i.first.op == JUMP) begin
                exp_q.push_back(squash_record(model_id + 1'b1));
            end else begin
                exp_q.push_back(model_result(pair_i.second, model_id + 1'b1));
            end
            model_id = model_id + COMMIT_ID_WIDTH'(2);
            accepted += 2;
            fired     = 1'b1;
            prev_fire = 1'b1;
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic advance();
        #1;
        observe();
        @(negedge clk);
    endtask

    task automatic send_pair(input exu_pair_t p, input int gap);
        pair_valid_i = 1'b0;
        repeat (gap) advance();
        pair_valid_i = 1'b1;
        pair_i       = p;
        fired        = 1'b0;
        // held until the handshake
        while (!fired) begin
            advance();
        end
        pair_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        pair_valid_i = 1'b0;
        waited       = 0;
        while (exp_q.size() != 0 && waited < 64) begin
            advance();
            waited++;
        end
        // idle tail catches stray retires
        repeat (4) advance();
    endtask

    task automatic open_test();
        accepted       = 0;
        retired        = 0;
        errors_at_open = errors;
    endtask

    task automatic close_test(input string name);
        drain();
        check_count("outstanding ids", exp_q.size(), 0);
        check_count("retired ids", retired, accepted);
        tests++;
        $display("%s: %0d ids retired, %0d errors", name, retired, errors - errors_at_open);
    endtask

    initial begin
        int k;
        int gap;
        pair_valid_i = 1'b0;
        pair_i       = '0;
        int_assert_i = 1'b0;
        arst_n_i     = 1'b0;
        lcg_state    = 32'hfd50775b;
        model_id     = '0;
        fired        = 1'b0;
        prev_fire    = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        #1;
        // idle handshake state out of reset
        check_flag("pair_ready_o after reset", pair_ready_o, 1'b1);
        check_flag("retire_valid_o after reset", retire_valid_o, 1'b0);
        @(negedge clk);

        open_test();
        for (k = 0; k < N_ARITH; k++) begin
            send_pair(rand_pair(0), int'(lcg_next() % 32'd4));
        end
        close_test("arith_pairs");

        open_test();
        for (k = 0; k < N_JUMP; k++) begin
            send_pair(rand_pair(2), int'(lcg_next() % 32'd3));
        end
        close_test("jump_squash");

        // 40 ids, wraps the 4-bit id twice
        open_test();
        for (k = 0; k < N_WRAP; k++) begin
            send_pair(rand_pair(1), int'(lcg_next() % 32'd2));
        end
        close_test("id_wraparound");

        open_test();
        for (k = 0; k < N_B2B; k++) begin
            send_pair(rand_pair(1), 0);
        end
        close_test("back_to_back");

        // flush hits at a random point, maybe on a pending second
        open_test();
        for (k = 0; k < 3; k++) begin
            repeat (4) send_pair(rand_pair(1), 0);
            gap = int'(lcg_next() % 32'd6);
            repeat (gap) advance();
            int_assert_i = 1'b1;
            advance();
            int_assert_i = 1'b0;
            repeat (4) send_pair(rand_pair(1), int'(lcg_next() % 32'd3));
            drain();
        end
        close_test("interrupt_flush");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // generous budget per pair
    initial begin
        #(TOTAL_PAIRS * 40 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the retire stream stalled",
                 TOTAL_PAIRS * 40);
        $display("Test failed");
        $finish;
    end

endmodule
